// File: source/io_select_pkg.sv
package io_select_pkg;

    // =========================================================================
    // Field widths
    // =========================================================================

    typedef logic [6:0]  io_addr_t;   // a7 down to a1, bit 0 is a1.
    typedef logic [2:0]  io_phase_t;
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // =========================================================================
    // Command, select and owner types
    // =========================================================================

    typedef struct packed {
        logic     wr;                 // 1 for an output command, 0 for an input.
        io_addr_t addr;
    } io_cmd_t;

    typedef struct packed {
        logic dara;
        logic lga;
        logic icr;
        logic ssr;
        logic dor;
        logic dos;
        logic ssa;
        logic tsa;
        logic diad;
        logic disa;
        logic crca;
    } io_sel_t;

    typedef enum logic [1:0] {
        OWNER_NONE    = 2'd0,
        OWNER_HOST    = 2'd1,
        OWNER_ADAPTER = 2'd2
    } io_owner_t;

    // Event positions inside one word time.
    localparam io_phase_t PHASE_GRANT  = 3'd0;
    localparam io_phase_t PHASE_STROBE = 3'd2;
    localparam io_phase_t PHASE_CLEAR  = 3'd6;

    localparam int unsigned ADDR_A3 = 2;
    localparam int unsigned ADDR_A4 = 3;
    localparam int unsigned ADDR_A5 = 4;
    localparam int unsigned ADDR_A6 = 5;
    localparam int unsigned ADDR_A7 = 6;

    localparam apb_addr_t APB_OFS_CMD = 32'h0000_0000;
    localparam apb_addr_t APB_OFS_SEL = 32'h0000_0004;

endpackage

// File: source/io_phase_gen.sv
`timescale 1ns/1ps

module io_phase_gen #(
    parameter int unsigned WORD_CYCLES = 8
) (
    input  logic sim_clk,
    input  logic rst_n,
    output logic phase_grant,
    output logic phase_strobe,
    output logic phase_clear
);

    import io_select_pkg::*;

    // the counter is never narrower than a phase value.
    localparam int unsigned CNT_W = ($clog2(WORD_CYCLES) > $bits(io_phase_t)) ?
                                    $clog2(WORD_CYCLES) : $bits(io_phase_t);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(WORD_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    if (WORD_CYCLES < 7) begin : g_word_too_short
        $error("io_phase_gen needs at least seven cycles per word time");
    end

    // =========================================================================
    // Word time counter
    // =========================================================================

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == LAST) begin
            cnt <= '0;                                  // next word time starts.
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Stand-ins for the v1, v4, w8, y8 and x3 timing pulses.
    assign phase_grant  = (cnt == CNT_W'(PHASE_GRANT));
    assign phase_strobe = (cnt == CNT_W'(PHASE_STROBE));
    assign phase_clear  = (cnt == CNT_W'(PHASE_CLEAR));

    a_events_apart: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        $onehot0({phase_grant, phase_strobe, phase_clear})
    ) else $error("two phase events fired in one cycle");

endmodule

// File: source/io_bus_arbiter.sv
`timescale 1ns/1ps

module io_bus_arbiter (
    input  logic                   sim_clk,
    input  logic                   rst_n,
    input  logic                   phase_grant,
    input  logic                   phase_clear,
    input  logic                   host_req,
    input  io_select_pkg::io_cmd_t host_cmd,
    input  logic                   adp_valid,
    input  io_select_pkg::io_cmd_t adp_cmd,
    output io_select_pkg::io_cmd_t bus_cmd,
    output io_select_pkg::io_owner_t bus_owner,
    output logic                   host_done,
    output logic                   adp_ack
);

    import io_select_pkg::*;

    typedef enum logic {
        IDLE,
        OWNED
    } arb_state_t;

    arb_state_t state;
    logic       last_host;                              // host won the last grant.
    logic       pick_host;
    logic       grant_now;
    logic       release_now;

    // the host goes first unless it was the last winner and the adapter waits.
    assign pick_host   = host_req && (!adp_valid || !last_host);
    assign grant_now   = (state == IDLE) && phase_grant && (host_req || adp_valid);
    assign release_now = (state == OWNED) && phase_clear;

    // =========================================================================
    // Ownership for one word time
    // =========================================================================

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            bus_owner <= OWNER_NONE;
            last_host <= 1'b0;
        end else if (grant_now) begin
            state     <= OWNED;
            bus_owner <= pick_host ? OWNER_HOST : OWNER_ADAPTER;
            last_host <= pick_host;
        end else if (release_now) begin
            state     <= IDLE;
            bus_owner <= OWNER_NONE;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (grant_now) begin
            bus_cmd <= pick_host ? host_cmd : adp_cmd;
        end
    end

    // completion pulses come on the clear phase of the owned word time.
    assign host_done = release_now && (bus_owner == OWNER_HOST);
    assign adp_ack   = release_now && (bus_owner == OWNER_ADAPTER);

    a_one_done: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        !(host_done && adp_ack)
    ) else $error("host_done and adp_ack pulsed together");

endmodule

// File: source/apb_pio_port.sv
`timescale 1ns/1ps

module apb_pio_port (
    input  logic                     sim_clk,
    input  logic                     rst_n,
    input  io_select_pkg::apb_addr_t paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  io_select_pkg::apb_data_t pwdata,
    output io_select_pkg::apb_data_t prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     host_req,
    output io_select_pkg::io_cmd_t   host_cmd,
    input  logic                     host_done,
    input  io_select_pkg::io_sel_t   sel
);

    import io_select_pkg::*;

    logic    hit_cmd;
    logic    hit_sel;
    logic    access;
    logic    wr_cmd_access;
    logic    submit;
    logic    done_q;                                    // host_done delayed by one.
    io_sel_t sel_snap;

    assign hit_cmd       = (paddr == APB_OFS_CMD);
    assign hit_sel       = (paddr == APB_OFS_SEL);
    assign access        = psel && penable;
    assign wr_cmd_access = access && pwrite && hit_cmd;

    // a stretched write submits once and then waits for its own completion.
    assign submit = wr_cmd_access && !host_req && !done_q;

    // =========================================================================
    // Command hand-off to the arbiter
    // =========================================================================

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            host_req <= 1'b0;
            done_q   <= 1'b0;
            sel_snap <= '0;
        end else begin
            done_q <= host_done;
            if (host_done) begin
                host_req <= 1'b0;
                sel_snap <= sel;                        // selects are still up here.
            end else if (submit) begin
                host_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge sim_clk) begin
        if (submit) begin
            host_cmd <= io_cmd_t'(pwdata[$bits(io_cmd_t)-1:0]);
        end
    end

    // =========================================================================
    // APB response
    // =========================================================================

    assign pready  = psel && (!wr_cmd_access || done_q);
    assign pslverr = access && !(hit_cmd || hit_sel);

    always_comb begin
        prdata = '0;
        if (hit_cmd) begin
            prdata[0] = host_req;                       // busy bit.
        end else if (hit_sel) begin
            prdata[$bits(io_sel_t)-1:0] = sel_snap;
        end
    end

    a_done_needs_req: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        host_done |-> host_req
    ) else $error("host_done without a pending host command");

endmodule

// File: source/io_addr_decode.sv
`timescale 1ns/1ps

module io_addr_decode (
    input  logic                     sim_clk,
    input  logic                     rst_n,
    input  logic                     phase_strobe,
    input  logic                     phase_clear,
    input  io_select_pkg::io_cmd_t   bus_cmd,
    input  io_select_pkg::io_owner_t bus_owner,
    output io_select_pkg::io_sel_t   sel,
    output io_select_pkg::io_owner_t sel_owner
);

    import io_select_pkg::*;

    logic       a3;
    logic       a4;
    logic       a5;
    logic       a6;
    logic       a7;
    logic [2:0] a543;
    io_sel_t    read_sel;
    io_sel_t    write_sel;
    io_sel_t    next_sel;

    assign a3   = bus_cmd.addr[ADDR_A3];
    assign a4   = bus_cmd.addr[ADDR_A4];
    assign a5   = bus_cmd.addr[ADDR_A5];
    assign a6   = bus_cmd.addr[ADDR_A6];
    assign a7   = bus_cmd.addr[ADDR_A7];
    assign a543 = {a5, a4, a3};

    // =========================================================================
    // Input select decode
    // =========================================================================

    always_comb begin
        read_sel = '0;
        if (!bus_cmd.wr && !a7 && a6) begin
            case (a543)
                3'b000: begin
                    read_sel.crca = 1'b1;
                end
                3'b010: begin
                    read_sel.disa = 1'b1;
                end
                3'b011: begin
                    read_sel.diad = 1'b1;
                end
                3'b101: begin
                    read_sel.tsa = 1'b1;
                end
                3'b111: begin
                    read_sel.ssa = 1'b1;
                end
                default: begin
                    read_sel = '0;                      // unmatched input address.
                end
            endcase
        end
    end

    // =========================================================================
    // Output select decode
    // =========================================================================

    always_comb begin
        write_sel = '0;
        if (bus_cmd.wr) begin
            if (a7) begin
                write_sel.lga = 1'b1;
            end else if (!a6) begin
                case (a543)
                    3'b011: begin
                        write_sel.dos = 1'b1;
                        write_sel.dor = 1'b1;
                    end
                    3'b010: begin
                        write_sel.dor = 1'b1;
                    end
                    3'b111: begin
                        write_sel.ssr = 1'b1;
                    end
                    3'b100, 3'b101: begin
                        write_sel.icr = 1'b1;           // a5 set with a4 clear.
                    end
                    default: begin
                        write_sel = '0;
                    end
                endcase
            end
        end
    end

    always_comb begin
        next_sel      = read_sel | write_sel;
        next_sel.dara = (bus_owner == OWNER_ADAPTER);
    end

    // =========================================================================
    // Select latches
    // =========================================================================

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            sel       <= '0;
            sel_owner <= OWNER_NONE;
        end else if (phase_clear) begin
            sel       <= '0;
            sel_owner <= OWNER_NONE;
        end else if (phase_strobe && (bus_owner != OWNER_NONE)) begin
            sel       <= next_sel;
            sel_owner <= bus_owner;
        end
    end

    a_one_read_sel: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        $onehot0({sel.ssa, sel.tsa, sel.diad, sel.disa, sel.crca})
    ) else $error("more than one input select is high");

    // the arbiter must hold the owner for as long as its selects are up.
    a_owner_held: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        (sel_owner != OWNER_NONE) |-> (sel_owner == bus_owner)
    ) else $error("bus owner changed while its selects were latched");

endmodule

// File: source/io_select_top.sv
`timescale 1ns/1ps

module io_select_top #(
    parameter int unsigned WORD_CYCLES = 8
) (
    input  logic                     sim_clk,
    input  logic                     rst_n,
    input  io_select_pkg::apb_addr_t paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  io_select_pkg::apb_data_t pwdata,
    output io_select_pkg::apb_data_t prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     adp_valid,
    input  io_select_pkg::io_cmd_t   adp_cmd,
    output logic                     adp_ack,
    output io_select_pkg::io_sel_t   sel,
    output io_select_pkg::io_owner_t sel_owner
);

    import io_select_pkg::*;

    logic      phase_grant;
    logic      phase_strobe;
    logic      phase_clear;
    logic      host_req;
    logic      host_done;
    io_cmd_t   host_cmd;
    io_cmd_t   bus_cmd;
    io_owner_t bus_owner;

    // =========================================================================
    // Timing, arbitration, host port and decode
    // =========================================================================

    io_phase_gen #(
        .WORD_CYCLES (WORD_CYCLES)
    ) u_phase_gen (
        .sim_clk      (sim_clk),
        .rst_n        (rst_n),
        .phase_grant  (phase_grant),
        .phase_strobe (phase_strobe),
        .phase_clear  (phase_clear)
    );

    io_bus_arbiter u_bus_arbiter (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .phase_grant (phase_grant),
        .phase_clear (phase_clear),
        .host_req    (host_req),
        .host_cmd    (host_cmd),
        .adp_valid   (adp_valid),
        .adp_cmd     (adp_cmd),
        .bus_cmd     (bus_cmd),
        .bus_owner   (bus_owner),
        .host_done   (host_done),
        .adp_ack     (adp_ack)
    );

    apb_pio_port u_apb_pio_port (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .host_req  (host_req),
        .host_cmd  (host_cmd),
        .host_done (host_done),
        .sel       (sel)
    );

    io_addr_decode u_addr_decode (
        .sim_clk      (sim_clk),
        .rst_n        (rst_n),
        .phase_strobe (phase_strobe),
        .phase_clear  (phase_clear),
        .bus_cmd      (bus_cmd),
        .bus_owner    (bus_owner),
        .sel          (sel),
        .sel_owner    (sel_owner)
    );

endmodule

// File: verif/tb_io_select.sv
`timescale 1ns/1ps

module tb_io_select;

    import io_select_pkg::*;

    localparam int unsigned WORD_CYCLES = 8;
    localparam int          WAIT_LIMIT  = 64;
    localparam int          FILLERS     = 8;

    typedef struct packed {
        logic      paired;                              // runs together with the next entry.
        io_owner_t src;
        io_cmd_t   cmd;
        io_sel_t   exp;
    } stim_t;

    logic        sim_clk;
    logic        rst_n;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        adp_valid;
    io_cmd_t     adp_cmd;
    logic        adp_ack;
    io_sel_t     sel;
    io_owner_t   sel_owner;

    stim_t       table_q[$];
    io_owner_t   rec_owner[$];                          // one entry per word time with an owner.
    io_sel_t     rec_sel[$];
    io_owner_t   prev_owner;
    io_owner_t   last_owner;
    io_sel_t     held_sel;
    int          hold_cycles;
    logic [31:0] lfsr_state;

    io_select_top #(
        .WORD_CYCLES (WORD_CYCLES)
    ) u_dut (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .adp_valid (adp_valid),
        .adp_cmd   (adp_cmd),
        .adp_ack   (adp_ack),
        .sel       (sel),
        .sel_owner (sel_owner)
    );

    always #4 sim_clk = ~sim_clk;

    // =========================================================================
    // Reporting and compare tasks
    // =========================================================================

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_sel(input string name, input io_sel_t got, input io_sel_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%03h expected 0x%03h", name, got, exp));
        end
    endtask

    task automatic check_owner(input string name, input io_owner_t got, input io_owner_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // =========================================================================
    // Reference decode and random fillers
    // =========================================================================

    function automatic io_sel_t ref_decode(input io_cmd_t cmd, input io_owner_t owner);
        io_sel_t    s;
        logic [2:0] f;
        s = '0;
        f = cmd.addr[4:2];                              // a5, a4, a3.
        if (!cmd.wr && (cmd.addr[6:5] == 2'b01)) begin
            s.crca = (f == 3'b000);
            s.disa = (f == 3'b010);
            s.diad = (f == 3'b011);
            s.tsa  = (f == 3'b101);
            s.ssa  = (f == 3'b111);
        end else if (cmd.wr && cmd.addr[6]) begin
            s.lga = 1'b1;
        end else if (cmd.wr && !cmd.addr[5]) begin
            s.dos = (f == 3'b011);
            s.dor = (f == 3'b011) || (f == 3'b010);
            s.ssr = (f == 3'b111);
            s.icr = (f[2:1] == 2'b10);
        end
        s.dara = (owner == OWNER_ADAPTER);
        return s;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic stim_t make_stim(input logic paired, input io_owner_t src,
                                        input io_cmd_t cmd, input io_sel_t exp);
        stim_t s;
        s.paired = paired;
        s.src    = src;
        s.cmd    = cmd;
        s.exp    = exp;
        return s;
    endfunction

    task automatic load_table;
        logic [31:0] v;
        io_owner_t   src;
        io_cmd_t     cmd;
        int          k;
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h20, 11'h001));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h28, 11'h002));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h2c, 11'h004));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h35, 11'h008));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h3e, 11'h010));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h24, 11'h000));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'hc5, 11'h200));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h8c, 11'h060));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h88, 11'h040));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h9c, 11'h080));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h90, 11'h100));
        table_q.push_back(make_stim(1'b0, OWNER_ADAPTER, 8'h34, 11'h408));
        table_q.push_back(make_stim(1'b0, OWNER_ADAPTER, 8'h88, 11'h440));
        table_q.push_back(make_stim(1'b0, OWNER_ADAPTER, 8'ha0, 11'h400));
        table_q.push_back(make_stim(1'b0, OWNER_ADAPTER, 8'h21, 11'h401));
        // contention pairs, both peers request in the same cycle.
        table_q.push_back(make_stim(1'b1, OWNER_HOST, 8'h28, 11'h002));
        table_q.push_back(make_stim(1'b0, OWNER_ADAPTER, 8'h8c, 11'h460));
        table_q.push_back(make_stim(1'b1, OWNER_ADAPTER, 8'h35, 11'h408));
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'hc5, 11'h200));
        // a lone host grant hands the next contested word time to the adapter.
        table_q.push_back(make_stim(1'b0, OWNER_HOST, 8'h94, 11'h100));
        table_q.push_back(make_stim(1'b1, OWNER_HOST, 8'h3e, 11'h010));
        table_q.push_back(make_stim(1'b0, OWNER_ADAPTER, 8'h94, 11'h500));
        for (k = 0; k < FILLERS; k++) begin
            take_bits(1, v);
            src = v[0] ? OWNER_ADAPTER : OWNER_HOST;
            take_bits(8, v);
            cmd = v[7:0];
            table_q.push_back(make_stim(1'b0, src, cmd, ref_decode(cmd, src)));
        end
    endtask

    // =========================================================================
    // Bus drivers
    // =========================================================================

    task automatic apb_write(input apb_data_t data);
        int n;
        @(posedge sim_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= APB_OFS_CMD;
        pwdata  <= data;
        @(posedge sim_clk);
        penable <= 1'b1;
        n = 0;
        @(negedge sim_clk);
        while (!pready) begin
            n = n + 1;
            if (n > WAIT_LIMIT) begin
                fail_run("pready never rose during a command write");
            end
            @(negedge sim_clk);
        end
        @(posedge sim_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        int n;
        @(posedge sim_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge sim_clk);
        penable <= 1'b1;
        n = 0;
        @(negedge sim_clk);
        while (!pready) begin
            n = n + 1;
            if (n > WAIT_LIMIT) begin
                fail_run("pready never rose during a read");
            end
            @(negedge sim_clk);
        end
        data = prdata;
        err  = pslverr;
        @(posedge sim_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic adp_send(input io_cmd_t cmd);
        int n;
        @(posedge sim_clk);
        adp_valid <= 1'b1;
        adp_cmd   <= cmd;
        n = 0;
        @(negedge sim_clk);
        while (!adp_ack) begin
            n = n + 1;
            if (n > WAIT_LIMIT) begin
                fail_run("adp_ack never came for an adapter command");
            end
            @(negedge sim_clk);
        end
        @(posedge sim_clk);
        adp_valid <= 1'b0;
        @(negedge sim_clk);
        if (adp_ack) begin
            fail_run("adp_ack stayed high for more than one cycle");
        end
    endtask

    // =========================================================================
    // Entry execution and record matching
    // =========================================================================

    task automatic run_entry(input stim_t e, input logic contend);
        apb_data_t data;
        logic      err;
        if (e.src == OWNER_ADAPTER) begin
            if (contend) begin
                repeat (2) @(posedge sim_clk);          // host_req rises on the third edge.
            end
            adp_send(e.cmd);
        end else begin
            apb_write({24'h0, e.cmd});
            apb_read(APB_OFS_SEL, data, err);
            if (err) begin
                fail_run("the selects readback returned a slave error");
            end
            check_data("prdata", data, {21'h0, e.exp});
        end
    endtask

    task automatic compare_single(input stim_t e);
        if (rec_owner.size() != 1) begin
            fail_run($sformatf("expected one owned word time, saw %0d", rec_owner.size()));
        end
        last_owner = rec_owner.pop_front();
        check_owner("sel_owner", last_owner, e.src);
        check_sel("sel", rec_sel.pop_front(), e.exp);
    endtask

    task automatic match_record(input io_owner_t o, input io_sel_t s, input stim_t a,
                                input stim_t b);
        if (o == a.src) begin
            check_sel("sel", s, a.exp);
        end else begin
            check_owner("sel_owner", o, b.src);
            check_sel("sel", s, b.exp);
        end
    endtask

    task automatic compare_pair(input stim_t a, input stim_t b);
        io_owner_t o0;
        io_owner_t o1;
        io_sel_t   s0;
        io_sel_t   s1;
        io_owner_t winner;
        if (rec_owner.size() != 2) begin
            fail_run($sformatf("expected two owned word times, saw %0d", rec_owner.size()));
        end
        // a contested grant goes to the peer that did not win the word time before.
        winner = (last_owner == OWNER_HOST) ? OWNER_ADAPTER : OWNER_HOST;
        o0 = rec_owner.pop_front();
        s0 = rec_sel.pop_front();
        o1 = rec_owner.pop_front();
        s1 = rec_sel.pop_front();
        check_owner("sel_owner", o0, winner);
        check_owner("sel_owner", o1, (winner == OWNER_HOST) ? OWNER_ADAPTER : OWNER_HOST);
        match_record(o0, s0, a, b);
        match_record(o1, s1, a, b);
        last_owner = o1;
    endtask

    task automatic poll_busy;
        apb_data_t data;
        logic      err;
        @(posedge sim_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= APB_OFS_CMD;
        pwdata  <= 32'h0000_009c;
        @(posedge sim_clk);
        penable <= 1'b1;
        @(posedge sim_clk);
        psel    <= 1'b0;                                // the first access cycle posted it.
        penable <= 1'b0;
        apb_read(APB_OFS_CMD, data, err);
        check_data("prdata", data, 32'h0000_0001);
        apb_write(32'h0000_009c);                       // waits on the posted command.
        apb_read(APB_OFS_SEL, data, err);
        check_data("prdata", data, 32'h0000_0080);
        compare_single(make_stim(1'b0, OWNER_HOST, 8'h9c, 11'h080));
    endtask

    // selects must hold for a whole owned window and be zero outside it.
    always @(negedge sim_clk) begin
        if (rst_n) begin
            if (sel_owner == OWNER_NONE) begin
                check_sel("sel", sel, '0);
                if ((prev_owner != OWNER_NONE) &&
                    (hold_cycles != int'(PHASE_CLEAR - PHASE_STROBE))) begin
                    fail_run($sformatf("selects stayed up for %0d cycles", hold_cycles));
                end
                hold_cycles = 0;
            end else if (prev_owner == OWNER_NONE) begin
                rec_owner.push_back(sel_owner);
                rec_sel.push_back(sel);
                held_sel    = sel;
                hold_cycles = 1;
            end else begin
                check_owner("sel_owner", sel_owner, prev_owner);
                check_sel("sel", sel, held_sel);
                hold_cycles = hold_cycles + 1;
            end
            prev_owner = sel_owner;
        end
    end

    initial begin
        apb_data_t data;
        logic      err;
        int        i;
        sim_clk     = 1'b0;
        rst_n       = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        adp_valid   = 1'b0;
        adp_cmd     = '0;
        prev_owner  = OWNER_NONE;
        last_owner  = OWNER_NONE;
        held_sel    = '0;
        hold_cycles = 0;
        lfsr_state  = 32'h36c4c482;
        load_table();
        repeat (10) @(posedge sim_clk);
        rst_n <= 1'b1;
        @(negedge sim_clk);
        check_sel("sel", sel, '0);
        check_owner("sel_owner", sel_owner, OWNER_NONE);
        if (adp_ack) begin
            fail_run("adp_ack is high right after reset");
        end
        if (pready) begin
            fail_run("pready is high right after reset");
        end
        i = 0;
        while (i < table_q.size()) begin
            if (table_q[i].paired && (i + 1 < table_q.size())) begin
                fork
                    run_entry(table_q[i], 1'b1);
                    run_entry(table_q[i + 1], 1'b1);
                join
                compare_pair(table_q[i], table_q[i + 1]);
                i = i + 2;
            end else begin
                run_entry(table_q[i], 1'b0);
                compare_single(table_q[i]);
                i = i + 1;
            end
        end
        poll_busy();
        apb_read(32'h0000_0008, data, err);
        if (!err) begin
            fail_run("APB offset 0x8 did not return a slave error");
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: files.f
source/io_select_pkg.sv
source/io_phase_gen.sv
source/io_bus_arbiter.sv
source/apb_pio_port.sv
source/io_addr_decode.sv
source/io_select_top.sv
verif/tb_io_select.sv

// File: Bender.yml
package:
  name: io_select

sources:
  - source/io_select_pkg.sv
  - source/io_phase_gen.sv
  - source/io_bus_arbiter.sv
  - source/apb_pio_port.sv
  - source/io_addr_decode.sv
  - source/io_select_top.sv
  - target: test
    files:
      - verif/tb_io_select.sv
